//--- core_frontend.f
+incdir+include
hw/frontend_pkg.sv
hw/fetch_pc.sv
hw/fetch_wb.sv
hw/inst_queue.sv
hw/inst_decoder.sv
hw/issue_buffer.sv
hw/core_frontend.sv
tb/tb_core_frontend.sv

//--- hw/core_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module core_frontend import frontend_pkg::*; #(
  parameter int QUEUE_DEPTH = frontend_pkg::QUEUE_DEPTH
) (
  input  logic           clk,
  input  logic           rst_n,
  output logic           wb_cyc_o,
  output logic           wb_stb_o,
  output logic [31:0]    wb_adr_o,
  input  logic [31:0]    wb_dat_i,
  input  logic           wb_ack_i,
  input  frontend_ctrl_t ctrl_i,
  input  logic [1:0]     issue_i,
  output logic [1:0]     inst_valid_o,
  output inst_t [1:0]    inst_o
);

  logic             fetch_en;
  logic [31:0]      group_pc;
  logic             group_done;
  logic             q_ready;
  logic [1:0]       q_wnum;
  fetch_pkt_t [1:0] q_wdata;
  logic [1:0]       q_rvalid;
  logic [1:0]       q_rnum;
  fetch_pkt_t [1:0] q_rdata;
  inst_t [1:0]      dec_inst;

  fetch_pc u_fetch_pc (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .group_done_i (group_done),
    .fetch_en_o   (fetch_en),
    .pc_o         (group_pc)
  );

  fetch_wb u_fetch_wb (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.redirect),
    .fetch_en_i   (fetch_en),
    .pc_i         (group_pc),
    .group_done_o (group_done),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .q_ready_i    (q_ready),
    .q_num_o      (q_wnum),
    .q_data_o     (q_wdata)
  );

  inst_queue #(
    .DEPTH     (QUEUE_DEPTH),
    .payload_t (fetch_pkt_t)
  ) u_inst_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (ctrl_i.redirect),
    .write_ready_o (q_ready),
    .write_num_i   (q_wnum),
    .write_data_i  (q_wdata),
    .read_valid_o  (q_rvalid),
    .read_num_i    (q_rnum),
    .read_data_o   (q_rdata)
  );

  for (genvar p = 0; p < 2; p++) begin : g_dec
    inst_decoder u_inst_decoder (
      .inst_i (q_rdata[p].inst),
      .pc_i   (q_rdata[p].pc),
      .inst_o (dec_inst[p])
    );
  end

  issue_buffer u_issue_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (ctrl_i.redirect),
    .dec_valid_i  (q_rvalid),
    .dec_inst_i   (dec_inst),
    .issue_i      (issue_i),
    .take_num_o   (q_rnum),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

endmodule

`default_nettype wire

//--- hw/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc import frontend_pkg::*; (
  input  logic           clk,
  input  logic           rst_n,
  input  frontend_ctrl_t ctrl_i,
  input  logic           group_done_i,
  output logic           fetch_en_o,
  output logic [31:0]    pc_o
);

  logic [31:0] pc_q;
  logic        idle_lock_q;

  // redirect wins over sequential advance
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= 32'h0;
    end else if (ctrl_i.redirect) begin
      pc_q <= {ctrl_i.target[31:2], 2'b00};
    end else if (group_done_i) begin
      // next aligned 8-byte group
      pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  // idle lock, held until an interrupt shows up
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_lock_q <= 1'b0;
    end else if (ctrl_i.irq) begin
      idle_lock_q <= 1'b0;
    end else if (ctrl_i.wait_inst) begin
      idle_lock_q <= 1'b1;
    end
  end

  assign fetch_en_o = !idle_lock_q;
  assign pc_o       = pc_q;

endmodule

`default_nettype wire

//--- hw/fetch_wb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_wb import frontend_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             fetch_en_i,
  input  logic [31:0]      pc_i,
  output logic             group_done_o,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic [31:0]      wb_adr_o,
  input  logic [31:0]      wb_dat_i,
  input  logic             wb_ack_i,
  input  logic             q_ready_i,
  output logic [1:0]       q_num_o,
  output fetch_pkt_t [1:0] q_data_o
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_GAP, S_PUSH} state_e;

  state_e           state_q;
  logic             discard_q;
  logic [31:0]      adr_q;
  logic             start_hi_q;
  logic [1:0][31:0] word_q;
  logic             push;
  logic [31:0]      pc_lo;
  logic [31:0]      pc_hi;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= S_IDLE;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // pc_i is stale during a redirect cycle
          if (fetch_en_i && q_ready_i && !flush_i) begin
            state_q   <= S_REQ;
            discard_q <= 1'b0;
          end
        end
        S_REQ: begin
          if (wb_ack_i) begin
            if (discard_q || flush_i) begin
              state_q <= S_IDLE;
            end else if (adr_q[2]) begin
              state_q <= S_PUSH;
            end else begin
              state_q <= S_GAP;
            end
          end else if (flush_i) begin
            // let the bus cycle finish, then drop its data
            discard_q <= 1'b1;
          end
        end
        // cyc low for one cycle between the two words
        S_GAP:   state_q <= flush_i ? S_IDLE : S_REQ;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // address and collected words
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE) begin
      adr_q      <= {pc_i[31:2], 2'b00};
      start_hi_q <= pc_i[2];
    end else if (state_q == S_REQ && wb_ack_i) begin
      word_q[adr_q[2]] <= wb_dat_i;
      adr_q[2]         <= 1'b1;
    end
  end

  assign wb_cyc_o = (state_q == S_REQ);
  assign wb_stb_o = (state_q == S_REQ);
  assign wb_adr_o = adr_q;

  assign push         = (state_q == S_PUSH) && !flush_i;
  assign group_done_o = push;
  assign q_num_o      = push ? (start_hi_q ? 2'd1 : 2'd2) : 2'd0;

  assign pc_lo = {adr_q[31:3], 3'b000};
  assign pc_hi = {adr_q[31:3], 3'b100};

  // a group starting at the upper word puts it in port 0
  assign q_data_o[0].pc   = start_hi_q ? pc_hi : pc_lo;
  assign q_data_o[0].inst = start_hi_q ? word_q[1] : word_q[0];
  assign q_data_o[1].pc   = pc_hi;
  assign q_data_o[1].inst = word_q[1];

endmodule

`default_nettype wire

//--- hw/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

  // default number of queue entries
  localparam int QUEUE_DEPTH = 16;

  // immediate slice kept per instruction, inst[23:10]
  localparam int IMM_W = 14;

  typedef enum logic [2:0] {
    OP_INVALID = 3'd0,
    OP_ALU_RR  = 3'd1,
    OP_ALU_RI  = 3'd2,
    OP_LOAD    = 3'd3,
    OP_STORE   = 3'd4,
    OP_BRANCH  = 3'd5,
    OP_BL      = 3'd6,
    OP_IDLE    = 3'd7
  } op_class_e;

  // register 0 stands for no register
  typedef struct packed {
    logic [4:0] r_reg0;
    logic [4:0] r_reg1;
    logic [4:0] w_reg;
  } reg_info_t;

  // one fetched word, queue payload
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]      pc;
    op_class_e        op;
    reg_info_t        reg_info;
    logic [IMM_W-1:0] imm;
  } inst_t;

  // back-end controls into the frontend
  typedef struct packed {
    logic        redirect;
    logic [31:0] target;
    logic        wait_inst;
    logic        irq;
  } frontend_ctrl_t;

endpackage

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module inst_decoder import frontend_pkg::*; (
  input  logic [31:0] inst_i,
  input  logic [31:0] pc_i,
  output inst_t       inst_o
);

  op_class_e  op;
  logic [1:0] r0_sel;
  logic       r1_sel;
  logic [1:0] w_sel;

  // opcode match
  always_comb begin
    op     = OP_INVALID;
    r0_sel = `REG_R0_NONE;
    r1_sel = `REG_R1_NONE;
    w_sel  = `REG_W_NONE;
    if (inst_i[31:15] == `OPC_ADD_W || inst_i[31:15] == `OPC_SUB_W ||
        inst_i[31:15] == `OPC_AND || inst_i[31:15] == `OPC_OR) begin
      op     = OP_ALU_RR;
      r0_sel = `REG_R0_RK;
      r1_sel = `REG_R1_RJ;
      w_sel  = `REG_W_RD;
    end else if (inst_i[31:22] == `OPC_ADDI_W || inst_i[31:22] == `OPC_LD_W) begin
      op     = (inst_i[31:22] == `OPC_LD_W) ? OP_LOAD : OP_ALU_RI;
      r1_sel = `REG_R1_RJ;
      w_sel  = `REG_W_RD;
    end else if (inst_i[31:22] == `OPC_ST_W) begin
      op     = OP_STORE;
      r0_sel = `REG_R0_RD;
      r1_sel = `REG_R1_RJ;
    end else if (inst_i[31:26] == `OPC_BEQ || inst_i[31:26] == `OPC_BNE) begin
      op     = OP_BRANCH;
      r0_sel = `REG_R0_RD;
      r1_sel = `REG_R1_RJ;
    end else if (inst_i[31:26] == `OPC_BL) begin
      op    = OP_BL;
      w_sel = `REG_W_BL1;
    end else if (inst_i[31:15] == `OPC_IDLE) begin
      op = OP_IDLE;
    end
  end

  // register fields from the select codes
  always_comb begin
    inst_o.pc  = pc_i;
    inst_o.op  = op;
    inst_o.imm = inst_i[23:10];
    case (r0_sel)
      `REG_R0_RK: inst_o.reg_info.r_reg0 = inst_i[14:10];
      `REG_R0_RD: inst_o.reg_info.r_reg0 = inst_i[4:0];
      default:    inst_o.reg_info.r_reg0 = 5'd0;
    endcase
    inst_o.reg_info.r_reg1 = (r1_sel == `REG_R1_RJ) ? inst_i[9:5] : 5'd0;
    case (w_sel)
      `REG_W_RD:  inst_o.reg_info.w_reg = inst_i[4:0];
      `REG_W_BL1: inst_o.reg_info.w_reg = 5'd1;
      default:    inst_o.reg_info.w_reg = 5'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [63:0]
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           flush_i,
  output logic           write_ready_o,
  input  logic [1:0]     write_num_i,
  input  payload_t [1:0] write_data_i,
  output logic [1:0]     read_valid_o,
  input  logic [1:0]     read_num_i,
  output payload_t [1:0] read_data_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int ROWS  = DEPTH / 2;

  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] count_q;
  payload_t [1:0]   bank_rdata;

  // even entries in bank 0, odd entries in bank 1
  for (genvar b = 0; b < 2; b++) begin : g_bank
    payload_t         mem [ROWS];
    logic             wport;
    logic             rport;
    logic [PTR_W-1:0] widx;
    logic [PTR_W-1:0] ridx;

    // port that maps onto this bank this cycle
    assign wport = wptr_q[0] ^ (b != 0);
    assign rport = rptr_q[0] ^ (b != 0);
    assign widx  = wptr_q + PTR_W'(wport);
    assign ridx  = rptr_q + PTR_W'(rport);

    always_ff @(posedge clk) begin
      if (2'(wport) < write_num_i) begin
        mem[widx[PTR_W-1:1]] <= write_data_i[wport];
      end
    end

    assign bank_rdata[b] = mem[ridx[PTR_W-1:1]];
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      wptr_q  <= wptr_q + PTR_W'(write_num_i);
      rptr_q  <= rptr_q + PTR_W'(read_num_i);
      count_q <= count_q + CNT_W'(write_num_i) - CNT_W'(read_num_i);
    end
  end

  // oldest entry always on port 0
  assign read_data_o[0] = bank_rdata[rptr_q[0]];
  assign read_data_o[1] = bank_rdata[~rptr_q[0]];

  assign read_valid_o  = {count_q > CNT_W'(1), count_q != '0};
  assign write_ready_o = (count_q <= CNT_W'(DEPTH - 2));

endmodule

`default_nettype wire

//--- hw/issue_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module issue_buffer import frontend_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic [1:0]  dec_valid_i,
  input  inst_t [1:0] dec_inst_i,
  input  logic [1:0]  issue_i,
  output logic [1:0]  take_num_o,
  output logic [1:0]  inst_valid_o,
  output inst_t [1:0] inst_o
);

  logic [1:0]  valid_q;
  logic [1:0]  valid_n;
  inst_t [1:0] slot_q;
  inst_t [1:0] slot_n;

  always_comb begin
    valid_n    = valid_q;
    slot_n     = slot_q;
    take_num_o = 2'd0;
    case (valid_q)
      2'b00: begin
        valid_n    = dec_valid_i;
        slot_n     = dec_inst_i;
        take_num_o = 2'(dec_valid_i[0]) + 2'(dec_valid_i[1]);
      end
      2'b01: begin
        // single entry refills at most one slot
        if (dec_valid_i[0]) begin
          take_num_o = 2'd1;
          if (issue_i[0]) begin
            slot_n[0] = dec_inst_i[0];
          end else begin
            valid_n   = 2'b11;
            slot_n[1] = dec_inst_i[0];
          end
        end else if (issue_i[0]) begin
          valid_n = 2'b00;
        end
      end
      default: begin
        if (issue_i == 2'b01) begin
          // slot 1 moves down, refill behind it
          slot_n[0] = slot_q[1];
          if (dec_valid_i[0]) begin
            slot_n[1]  = dec_inst_i[0];
            take_num_o = 2'd1;
          end else begin
            valid_n = 2'b01;
          end
        end else if (issue_i[1]) begin
          valid_n    = dec_valid_i;
          slot_n     = dec_inst_i;
          take_num_o = 2'(dec_valid_i[0]) + 2'(dec_valid_i[1]);
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= valid_n;
    end
    slot_q <= slot_n;
  end

  assign inst_valid_o = valid_q;
  assign inst_o       = slot_q;

endmodule

`default_nettype wire

//--- include/frontend_defs.svh
`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// register select codes
`define REG_R0_NONE 2'd0
`define REG_R0_RK   2'd1
`define REG_R0_RD   2'd2
`define REG_R1_NONE 1'b0
`define REG_R1_RJ   1'b1
`define REG_W_NONE  2'd0
`define REG_W_RD    2'd1
`define REG_W_BL1   2'd2

// 3R and idle match inst[31:15]
`define OPC_ADD_W  17'h00020
`define OPC_SUB_W  17'h00022
`define OPC_AND    17'h00029
`define OPC_OR     17'h0002a
`define OPC_IDLE   17'h00c91
// 2RI12 forms match inst[31:22]
`define OPC_ADDI_W 10'h00a
`define OPC_LD_W   10'h0a2
`define OPC_ST_W   10'h0a6
// branches match inst[31:26]
`define OPC_BEQ    6'h16
`define OPC_BNE    6'h17
`define OPC_BL     6'h15

`endif

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_core_frontend \
  -f core_frontend.f -o sim_core_frontend

./obj_dir/sim_core_frontend > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
exit 0

//--- tb/tb_core_frontend.sv
`timescale 1ns/1ps
`default_nettype none

`include "frontend_defs.svh"

module tb_core_frontend import frontend_pkg::*; ();

  // six phases of up to 300 instructions at 6 cycles each, plus margin
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] SEED           = 32'h70bb_5fcf;

  logic           clk;
  logic           rst_n;
  logic           wb_cyc;
  logic           wb_stb;
  logic [31:0]    wb_adr;
  logic [31:0]    mem_dat;
  logic           mem_ack;
  frontend_ctrl_t ctrl;
  logic [1:0]     issue;
  logic [1:0]     inst_valid;
  inst_t [1:0]    inst_out;

  logic [31:0] mem [256];
  logic [1:0]  wait_left;
  integer      seed;
  integer      wait_seed;
  logic [31:0] model_pc;
  logic        expect_target;
  logic [31:0] target_pc;
  int          accepted_count;
  int          error_count;
  int          cycle_count;
  int          test_err_base;

  core_frontend #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_adr_o     (wb_adr),
    .wb_dat_i     (mem_dat),
    .wb_ack_i     (mem_ack),
    .ctrl_i       (ctrl),
    .issue_i      (issue),
    .inst_valid_o (inst_valid),
    .inst_o       (inst_out)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // LA32R subset word, or a raw random word for the top kinds
  function automatic logic [31:0] make_word(input logic [3:0] kind, input logic [31:0] r);
    case (kind)
      4'd0:    return {`OPC_ADD_W, r[14:0]};
      4'd1:    return {`OPC_SUB_W, r[14:0]};
      4'd2:    return {`OPC_AND, r[14:0]};
      4'd3:    return {`OPC_OR, r[14:0]};
      4'd4:    return {`OPC_ADDI_W, r[21:0]};
      4'd5:    return {`OPC_LD_W, r[21:0]};
      4'd6:    return {`OPC_ST_W, r[21:0]};
      4'd7:    return {`OPC_BEQ, r[25:0]};
      4'd8:    return {`OPC_BNE, r[25:0]};
      4'd9:    return {`OPC_BL, r[25:0]};
      4'd10:   return {`OPC_IDLE, r[14:0]};
      default: return r;
    endcase
  endfunction

  function automatic inst_t expected_decode(input logic [31:0] word, input logic [31:0] pc);
    inst_t e;
    e     = '0;
    e.pc  = pc;
    e.imm = word[23:10];
    e.op  = OP_INVALID;
    if (word[31:15] inside {`OPC_ADD_W, `OPC_SUB_W, `OPC_AND, `OPC_OR}) begin
      e.op = OP_ALU_RR;
    end else if (word[31:15] == `OPC_IDLE) begin
      e.op = OP_IDLE;
    end else if (word[31:22] == `OPC_ADDI_W) begin
      e.op = OP_ALU_RI;
    end else if (word[31:22] == `OPC_LD_W) begin
      e.op = OP_LOAD;
    end else if (word[31:22] == `OPC_ST_W) begin
      e.op = OP_STORE;
    end else if (word[31:26] == `OPC_BEQ || word[31:26] == `OPC_BNE) begin
      e.op = OP_BRANCH;
    end else if (word[31:26] == `OPC_BL) begin
      e.op = OP_BL;
    end
    // rd in [4:0], rj in [9:5], rk in [14:10]
    case (e.op)
      OP_ALU_RR: e.reg_info = {word[14:10], word[9:5], word[4:0]};
      OP_ALU_RI, OP_LOAD: e.reg_info = {5'd0, word[9:5], word[4:0]};
      OP_STORE, OP_BRANCH: e.reg_info = {word[4:0], word[9:5], 5'd0};
      OP_BL: e.reg_info = {5'd0, 5'd0, 5'd1};
      default: e.reg_info = '0;
    endcase
    return e;
  endfunction

  // slot 1 only together with slot 0
  function automatic logic [1:0] random_issue();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0:    return 2'b00;
      2'd1:    return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  task automatic run_stream(input int count);
    int goal;
    goal = accepted_count + count;
    while (accepted_count < goal) begin
      @(posedge clk);
      issue <= random_issue();
    end
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    $display("%s done, %0d errors", name, error_count - test_err_base);
    test_err_base = error_count;
  endtask

  // Wishbone slave, 0 to 2 wait cycles per word
  initial begin : wb_memory
    logic [31:0] r;
    wait_seed = SEED;
    mem_ack   <= 1'b0;
    mem_dat   <= 32'h0;
    wait_left <= 2'd0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        mem_ack   <= 1'b0;
        wait_left <= 2'd0;
      end else if (mem_ack) begin
        mem_ack <= 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (wait_left == 2'd0) begin
          r = $random(wait_seed);
          mem_ack   <= 1'b1;
          mem_dat   <= mem[wb_adr[9:2]];
          wait_left <= 2'(r % 32'd3);
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end
    end
  end

  // scoreboard, one model pc for the whole accepted stream
  always @(posedge clk) begin : check_accepts
    logic [31:0] pc_v;
    int          n_v;
    logic        acc;
    inst_t       exp_v;
    if (!rst_n) begin
      model_pc       <= 32'h0;
      accepted_count <= 0;
      expect_target  = 1'b0;
    end else begin
      pc_v = model_pc;
      n_v  = 0;
      for (int k = 0; k < 2; k++) begin
        acc = (k == 0) ? (issue[0] && inst_valid[0]) : (issue == 2'b11 && inst_valid[1]);
        if (acc) begin
          exp_v = expected_decode(mem[pc_v[9:2]], pc_v);
          if (inst_out[k] !== exp_v) begin
            $display("[ERROR] inst_o[%0d]: got %h, expected %h", k, inst_out[k], exp_v);
            error_count++;
          end
          if (k == 0 && expect_target) begin
            if (inst_out[0].pc !== target_pc) begin
              $display("[ERROR] inst_o[0].pc after redirect: got %h, expected %h",
                       inst_out[0].pc, target_pc);
              error_count++;
            end
            expect_target = 1'b0;
          end
          pc_v = pc_v + 32'd4;
          n_v++;
        end
      end
      if (ctrl.redirect) begin
        pc_v          = ctrl.target;
        target_pc     = ctrl.target;
        expect_target = 1'b1;
      end
      model_pc       <= pc_v;
      accepted_count <= accepted_count + n_v;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the instruction stream stalled", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin : main_seq
    logic [31:0] r_kind;
    logic [31:0] r_bits;
    logic [1:0]  snap_valid;
    inst_t [1:0] snap_inst;
    int          low_run;
    int          cyc_seen;
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      r_kind = $random(seed);
      r_bits = $random(seed);
      mem[i] = make_word(4'(r_kind % 32'd13), r_bits);
    end
    rst_n <= 1'b0;
    issue <= 2'b00;
    ctrl  <= '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    // first cycle out of reset
    @(negedge clk);
    if (wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
      $display("[ERROR] wb_cyc_o/wb_stb_o: got %h/%h, expected 0/0", wb_cyc, wb_stb);
      error_count++;
    end
    if (inst_valid !== 2'b00) begin
      $display("[ERROR] inst_valid_o: got %h, expected 0", inst_valid);
      error_count++;
    end
    finish_test("test 1 reset values");

    run_stream(300);
    finish_test("test 2 sequential stream");

    // hold issue low until both slots are full, then watch for 200 cycles
    @(posedge clk);
    issue <= 2'b00;
    do begin
      @(posedge clk);
    end while (inst_valid != 2'b11);
    snap_valid = inst_valid;
    snap_inst  = inst_out;
    cyc_seen   = 0;
    for (int i = 0; i < 200; i++) begin
      @(posedge clk);
      if (inst_valid !== snap_valid || inst_out !== snap_inst) begin
        $display("[ERROR] inst_valid_o/inst_o: changed from %h/%h to %h/%h",
                 snap_valid, snap_inst, inst_valid, inst_out);
        error_count++;
      end
      if (i >= 150 && wb_cyc) begin
        cyc_seen++;
      end
    end
    if (cyc_seen != 0) begin
      $display("fetch kept running on the bus with a full queue");
      error_count++;
    end
    run_stream(300);
    finish_test("test 3 back-pressure");

    run_stream(50);
    @(posedge clk);
    r_bits = $random(seed);
    issue         <= 2'b00;
    ctrl.redirect <= 1'b1;
    ctrl.target   <= (r_bits & 32'h0000_03f8) | 32'h4;
    @(posedge clk);
    ctrl.redirect <= 1'b0;
    issue         <= random_issue();
    run_stream(300);
    finish_test("test 4 redirect");

    run_stream(50);
    @(posedge clk);
    ctrl.wait_inst <= 1'b1;
    issue          <= random_issue();
    @(posedge clk);
    ctrl.wait_inst <= 1'b0;
    // a group already started may still finish its words
    low_run = 0;
    while (low_run < 3) begin
      @(posedge clk);
      issue <= random_issue();
      if (!wb_cyc) begin
        low_run++;
      end else begin
        low_run = 0;
      end
    end
    cyc_seen = 0;
    repeat (100) begin
      @(posedge clk);
      issue <= random_issue();
      if (wb_cyc) begin
        cyc_seen++;
      end
    end
    if (cyc_seen != 0) begin
      $display("a bus cycle started while the idle lock was set");
      error_count++;
    end
    @(posedge clk);
    ctrl.irq <= 1'b1;
    @(posedge clk);
    ctrl.irq <= 1'b0;
    run_stream(300);
    finish_test("test 5 idle wait");

    $display("%0d instructions checked, %0d errors", accepted_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
